// File: common/rotate_pkg.sv
// rotate unit shared definitions

package rotate_pkg;

    // width of the rotated feedback word
    localparam int DATA_WIDTH = 8;

    // bits per lookahead block, fixed by the 4-bit lookahead terms
    localparam int BLOCK_WIDTH = 4;

    // number of lookahead blocks across the word
    localparam int NUM_BLOCKS = DATA_WIDTH / BLOCK_WIDTH;

    // one data word
    typedef logic [DATA_WIDTH-1:0] word_t;

    // one block slice of operand, propagate, generate or sum bits
    typedef logic [BLOCK_WIDTH-1:0] nibble_t;

    // carry into each block, plus the final carry out at the top
    typedef logic [NUM_BLOCKS:0] block_carry_t;

    // one pipeline stage, also the bundle seen at the top level
    // valid and carry ride along with the sum word
    typedef struct packed {
        logic  valid;
        logic  carry;
        word_t data;
    } stage_t;

endpackage : rotate_pkg

// File: logic/lookahead_block.sv
// 4-bit lookahead carry block

module lookahead_block
    import rotate_pkg::*;
(
    input  nibble_t a,
    input  nibble_t b,
    input  logic    carry_in,
    output nibble_t sum,
    output logic    block_generate,
    output logic    block_propagate
);

    // per-bit propagate and generate
    nibble_t bit_propagate;
    nibble_t bit_generate;

    // carry into each bit of the block, bit 0 takes the block carry
    nibble_t bit_carry;

    assign bit_propagate = a ^ b;
    assign bit_generate  = a & b;

    // ripple inside the block
    always_comb begin
        bit_carry[0] = carry_in;
        for (int i = 1; i < BLOCK_WIDTH; i++) begin
            bit_carry[i] = bit_generate[i-1] | (bit_propagate[i-1] & bit_carry[i-1]);
        end
    end

    assign sum = bit_propagate ^ bit_carry;

    // block terms for the chain between blocks
    assign block_propagate = &bit_propagate;

    assign block_generate = bit_generate[3]
                          | (bit_propagate[3] & bit_generate[2])
                          | (bit_propagate[3] & bit_propagate[2] & bit_generate[1])
                          | (bit_propagate[3] & bit_propagate[2] & bit_propagate[1]
                             & bit_generate[0]);

endmodule : lookahead_block

// File: logic/block_carry_adder.sv
// word-wide block carry-lookahead adder

module block_carry_adder
    import rotate_pkg::*;
(
    input  word_t op_a,
    input  word_t op_b,
    output word_t sum,
    output logic  carry_out
);

    // carry chain between blocks
    // entry 0 feeds block 0, the top entry is the word carry
    block_carry_t block_carry;

    // block terms returned by each lookahead block
    logic [NUM_BLOCKS-1:0] block_generate;
    logic [NUM_BLOCKS-1:0] block_propagate;

    // no carry into the word
    assign block_carry[0] = 1'b0;

    for (genvar blk = 0; blk < NUM_BLOCKS; blk++) begin : gen_block

        // operand slices for this block
        nibble_t blk_a;
        nibble_t blk_b;
        nibble_t blk_sum;

        assign blk_a = op_a[blk*BLOCK_WIDTH +: BLOCK_WIDTH];
        assign blk_b = op_b[blk*BLOCK_WIDTH +: BLOCK_WIDTH];

        lookahead_block u_block (
            .a               (blk_a),
            .b               (blk_b),
            .carry_in        (block_carry[blk]),
            .sum             (blk_sum),
            .block_generate  (block_generate[blk]),
            .block_propagate (block_propagate[blk])
        );

        // next block carry from this block's terms only
        assign block_carry[blk+1] = block_generate[blk]
                                  | (block_propagate[blk] & block_carry[blk]);

        // block sums land side by side in the word
        assign sum[blk*BLOCK_WIDTH +: BLOCK_WIDTH] = blk_sum;

    end : gen_block

    assign carry_out = block_carry[NUM_BLOCKS];

endmodule : block_carry_adder

// File: rotate_shifter/carry_rotate_shifter.sv
// rotate-through-carry feedback pipeline

module carry_rotate_shifter
    import rotate_pkg::*;
(
    input  logic   clk,
    input  logic   rst_n,
    input  logic   en,
    input  logic   valid_in,
    input  logic   carry_in,
    output stage_t result
);

    // pipeline registers
    stage_t stage1;
    stage_t stage2;

    // value loaded into stage1 on the next enabled edge
    stage_t stage1_next;

    // adder operands and results
    word_t op_a;
    word_t op_b;
    word_t sum;
    logic  carry_out;

    // rotate left through carry, carry_in enters at bit 0
    assign op_a = {stage2.data[DATA_WIDTH-2:0], carry_in};

    // inverse of the fed back word
    assign op_b = ~stage2.data;

    block_carry_adder u_adder (
        .op_a      (op_a),
        .op_b      (op_b),
        .sum       (sum),
        .carry_out (carry_out)
    );

    always_comb begin
        stage1_next.valid = valid_in;
        stage1_next.carry = carry_out;
        stage1_next.data  = sum;
    end

    // stage 1 captures the adder result
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            stage1 <= '0;
        end else if (en) begin
            stage1 <= stage1_next;
        end
    end

    // stage 2 follows stage 1 and feeds the operands back
    // two sequences interleave, one in each stage
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            stage2 <= '0;
        end else if (en) begin
            stage2 <= stage1;
        end
    end

    // the output is the stage 2 register itself
    assign result = stage2;

endmodule : carry_rotate_shifter

// File: logic/rotate_unit_top.sv
// rotate unit top level

module rotate_unit_top
    import rotate_pkg::*;
(
    input  logic   clk,
    input  logic   rst_n,
    input  logic   en,
    input  logic   valid_in,
    input  logic   carry_in,
    output stage_t result
);

    // en is a level stall for the whole pipeline
    // valid_in shows up on result.valid two enabled edges later
    carry_rotate_shifter u_shifter (
        .clk      (clk),
        .rst_n    (rst_n),
        .en       (en),
        .valid_in (valid_in),
        .carry_in (carry_in),
        .result   (result)
    );

endmodule : rotate_unit_top

// File: verification/rotate_unit_sva.sv
// rotate unit assertions

module rotate_unit_sva
    import rotate_pkg::*;
(
    input logic   clk,
    input logic   rst_n,
    input logic   en,
    input logic   valid_in,
    input stage_t result
);

    // valid_in delayed by two enabled edges
    logic [1:0] valid_pipe;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_pipe <= '0;
        end else if (en) begin
            valid_pipe <= {valid_pipe[0], valid_in};
        end
    end

    // an edge under reset leaves the stages cleared
    property reset_clears_p;
        @(posedge clk) !rst_n |=> (result == '0);
    endproperty

    // en low freezes both stages
    property stall_holds_p;
        @(posedge clk) disable iff (!rst_n) !en |=> $stable(result);
    endproperty

    property valid_latency_p;
        @(posedge clk) disable iff (!rst_n) result.valid == valid_pipe[1];
    endproperty

    reset_clears_a: assert property (reset_clears_p)
        else $error("result not cleared while rst_n is low");

    stall_holds_a: assert property (stall_holds_p)
        else $error("result changed across an edge with en low");

    valid_latency_a: assert property (valid_latency_p)
        else $error("result.valid does not match valid_in from two enabled edges earlier");

endmodule : rotate_unit_sva

bind rotate_unit_top rotate_unit_sva u_sva (
    .clk      (clk),
    .rst_n    (rst_n),
    .en       (en),
    .valid_in (valid_in),
    .result   (result)
);

// File: verification/rotate_unit_tb.sv
// rotate unit testbench

module rotate_unit_tb
    import rotate_pkg::*;
();

    localparam int    CLK_PERIOD   = 40;
    localparam int    RESET_CYCLES = 3;
    localparam int    SLACK_CYCLES = 20;
    localparam string CASE_FILE    = "verification/rotate_unit_cases.txt";

    // one case line with its inputs and expected result
    typedef struct packed {
        logic   en;
        logic   valid_in;
        logic   carry_in;
        stage_t expected;
    } case_t;

    logic   clk;
    logic   rst_n;
    logic   en;
    logic   valid_in;
    logic   carry_in;
    stage_t result;

    // cases in file order with their test names
    string case_name[$];
    case_t case_q[$];

    int cycle_count  = 0;
    int cycle_limit  = 0;
    int test_checks  = 0;
    int test_errors  = 0;
    int total_errors = 0;
    int tests_passed = 0;
    int tests_failed = 0;

    rotate_unit_top u_dut (
        .clk      (clk),
        .rst_n    (rst_n),
        .en       (en),
        .valid_in (valid_in),
        .carry_in (carry_in),
        .result   (result)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // read all case lines and skip lines starting with #
    task automatic load_cases(output bit ok);
        int    fd;
        int    code;
        int    f_en;
        int    f_valid;
        int    f_carry;
        int    exp_valid;
        int    exp_carry;
        int    exp_data;
        string tok;
        string rest;
        bit    done;
        case_t entry;
        ok   = 1'b1;
        done = 1'b0;
        fd   = $fopen(CASE_FILE, "r");
        if (fd == 0) begin
            $display("could not open the case file %s", CASE_FILE);
            ok = 1'b0;
        end else begin
            while (!done) begin
                code = $fscanf(fd, "%s", tok);
                if (code != 1) begin
                    done = 1'b1;
                end else if (tok.getc(0) == "#") begin
                    code = $fgets(rest, fd);
                end else begin
                    code = $fscanf(fd, "%d %d %d %d %d %h",
                                   f_en, f_valid, f_carry, exp_valid, exp_carry, exp_data);
                    if (code != 6) begin
                        $display("case line for test %s is incomplete", tok);
                        ok   = 1'b0;
                        done = 1'b1;
                    end else begin
                        entry.en             = f_en[0];
                        entry.valid_in       = f_valid[0];
                        entry.carry_in       = f_carry[0];
                        entry.expected.valid = exp_valid[0];
                        entry.expected.carry = exp_carry[0];
                        entry.expected.data  = word_t'(exp_data);
                        case_name.push_back(tok);
                        case_q.push_back(entry);
                    end
                end
            end
            $fclose(fd);
            if (ok && case_q.size() == 0) begin
                $display("the case file holds no cases");
                ok = 1'b0;
            end
        end
    endtask

    // compare the DUT result with one expected bundle
    task automatic check_result(input string name, input stage_t expected, input int step);
        test_checks++;
        if (result !== expected) begin
            test_errors++;
            total_errors++;
            $display("Fail %s step %0d: expected v=%b c=%b d=%h, actual v=%b c=%b d=%h",
                     name, step, expected.valid, expected.carry, expected.data,
                     result.valid, result.carry, result.data);
        end
    endtask

    // one summary line per finished test
    task automatic finish_test(input string name);
        if (test_errors == 0) begin
            tests_passed++;
            $display("test %s passed, %0d checks", name, test_checks);
        end else begin
            tests_failed++;
            $display("test %s had %0d wrong of %0d checks", name, test_errors, test_checks);
        end
        test_checks = 0;
        test_errors = 0;
    endtask

    // stops a run that overstays the case count
    initial begin : watchdog
        wait (cycle_limit > 0);
        while (cycle_count < cycle_limit) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("run stopped after %0d cycles without finishing the cases", cycle_limit);
        $display("Something failed");
        $finish;
    end

    initial begin : main
        bit loaded;
        rst_n    = 1'b0;
        en       = 1'b0;
        valid_in = 1'b0;
        carry_in = 1'b0;
        load_cases(loaded);
        if (!loaded) begin
            $display("Something failed");
            $finish;
        end else begin
            cycle_limit = case_q.size() + RESET_CYCLES + SLACK_CYCLES;

            // result stays cleared while reset is held
            for (int r = 0; r < RESET_CYCLES; r++) begin
                @(negedge clk);
                check_result("reset_state", '0, r);
            end
            rst_n = 1'b1;

            // drive on the falling edge and check one cycle later
            for (int i = 0; i < case_q.size(); i++) begin
                if (i > 0 && case_name[i] != case_name[i-1]) begin
                    finish_test(case_name[i-1]);
                end
                en       = case_q[i].en;
                valid_in = case_q[i].valid_in;
                carry_in = case_q[i].carry_in;
                @(negedge clk);
                check_result(case_name[i], case_q[i].expected, i);
            end
            finish_test(case_name[case_q.size()-1]);

            $display("tests passed %0d, tests failed %0d, wrong checks %0d",
                     tests_passed, tests_failed, total_errors);
            if (tests_failed == 0 && total_errors == 0) begin
                $display("Everything OK");
            end else begin
                $display("Something failed");
            end
            $finish;
        end
    end

endmodule : rotate_unit_tb

// File: verification/rotate_unit_cases.txt
# columns: test en valid_in carry_in exp_valid exp_carry exp_data
# exp_data in hex, result after the rising edge that follows the drive
reset_state 0 0 0 0 0 00
reset_state 0 1 1 0 0 00
reset_state 0 0 1 0 0 00
carry_in_rotation 1 1 1 0 0 00
carry_in_rotation 1 0 1 1 1 00
carry_in_rotation 1 1 1 0 1 00
carry_in_rotation 1 1 1 1 1 00
carry_in_rotation 1 0 1 1 1 00
carry_out_overflow 1 0 1 0 1 00
carry_out_overflow 1 0 0 0 1 00
carry_out_overflow 1 0 1 0 0 ff
carry_out_overflow 1 0 1 0 1 00
carry_out_overflow 1 0 1 0 0 ff
carry_out_overflow 1 0 0 0 1 00
carry_out_overflow 1 0 1 0 0 fe
carry_out_overflow 1 0 0 0 1 00
valid_latency 1 0 1 0 0 fd
valid_latency 1 1 0 0 1 00
valid_latency 1 0 1 1 0 fc
valid_latency 1 0 0 0 1 00
valid_latency 1 0 1 0 0 fb
valid_latency 1 0 0 0 1 00
stall_hold 1 1 1 0 0 fa
stall_hold 0 0 0 0 0 fa
stall_hold 0 1 0 0 0 fa
stall_hold 0 0 1 0 0 fa
stall_hold 1 0 0 1 1 00
stall_hold 1 0 1 0 0 f9
stall_hold 1 0 1 0 1 00
long_mixed 1 0 0 0 0 f9
long_mixed 1 1 1 0 0 ff
long_mixed 0 0 0 0 0 ff
long_mixed 1 0 0 1 0 f9
long_mixed 1 1 0 0 0 fe
long_mixed 1 1 1 1 0 f8
long_mixed 0 0 1 1 0 f8
long_mixed 0 1 0 1 0 f8
long_mixed 1 0 0 1 0 fe
long_mixed 1 0 0 0 0 f7
long_mixed 1 1 0 0 0 fd
long_mixed 1 0 1 1 0 f6
long_mixed 1 0 0 0 0 fd
long_mixed 0 1 1 0 0 fd
long_mixed 1 1 1 0 0 f5
long_mixed 1 0 0 1 0 fd
long_mixed 1 0 0 0 0 f4
long_mixed 1 1 0 0 0 fc
long_mixed 1 1 0 1 0 f3
long_mixed 1 0 1 1 0 fb
long_mixed 0 0 0 1 0 fb
long_mixed 1 0 0 0 0 f3
long_mixed 1 0 0 0 0 fa
long_mixed 1 1 1 0 0 f2
long_mixed 1 0 0 1 0 fa
long_mixed 1 0 0 0 0 f1
long_mixed 0 1 0 0 0 f1
long_mixed 1 0 0 0 0 f9
long_mixed 1 0 0 0 0 f0
long_mixed 1 0 0 0 0 f8

// File: build.f
common/rotate_pkg.sv
logic/lookahead_block.sv
logic/block_carry_adder.sv
rotate_shifter/carry_rotate_shifter.sv
logic/rotate_unit_top.sv
verification/rotate_unit_sva.sv
verification/rotate_unit_tb.sv

// File: Bender.yml
package:
  name: rotate_unit

sources:
  # design, in compile order
  - common/rotate_pkg.sv
  - logic/lookahead_block.sv
  - logic/block_carry_adder.sv
  - rotate_shifter/carry_rotate_shifter.sv
  - logic/rotate_unit_top.sv

  # testbench and bound assertions
  - target: test
    files:
      - verification/rotate_unit_sva.sv
      - verification/rotate_unit_tb.sv
